// ==== Bender.yml ====
package:
  name: pma

sources:
  - files:
      - pmaPkg.sv
      - pmaBaseRegs.sv
      - pmaCcaCounter.sv
      - pmaCycleSelect.sv
      - pmaAddressMux.sv
      - pmaTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - pmaTb.sv

// ==== flist.f ====
+incdir+.
pmaPkg.sv
pmaBaseRegs.sv
pmaCcaCounter.sv
pmaCycleSelect.sv
pmaAddressMux.sv
pmaTop.sv
pmaTb.sv

// ==== pmaAddressMux.sv ====
`timescale 1ns/1ps

module pmaAddressMux #(
  parameter int PageWidth = pmaPkg::PageWidthDefault
) (
  input  logic            clock,
  input  logic            rstN,
  input  pmaPkg::srcSelT  selHigh,
  input  pmaPkg::srcSelT  sel27,
  input  pmaPkg::srcSelT  selMid,
  input  pmaPkg::srcSelT  selLow,
  input  pmaPkg::vmaWordT vma,
  input  pmaPkg::baseT    uebr,
  input  pmaPkg::paddrT   cca,
  input  pmaPkg::paddrT   pageTable,
  input  pmaPkg::paddrT   chanWord,
  input  pmaPkg::paddrT   cacheTag,
  input  logic            eboxEraGrant,
  output pmaPkg::paddrT   pa,
  output logic            adrPar,
  output logic            highPar
);

  import pmaPkg::*;

  localparam int HighLast = 13 + PageWidth;

  paddrT              era;
  logic [14:HighLast] highField;
  logic               bit27;
  logic [28:31]       midField;
  logic [32:35]       lowField;

  // Page number field.
  always_comb begin
    case (selHigh)
      selVma:       highField = vma.flat[14:HighLast];
      selBase:      highField = uebr;
      selChanWord:  highField = chanWord[14:HighLast];
      selCacheTag:  highField = cacheTag[14:HighLast];
      selCca:       highField = cca[14:HighLast];
      selEra:       highField = era[14:HighLast];
      selPageTable: highField = pageTable[14:HighLast];
      default:      highField = '0;
    endcase
  end

  always_comb begin
    case (sel27)
      selVma:      bit27 = vma.flat[27];
      selChanWord: bit27 = chanWord[27];
      selCacheTag: bit27 = cacheTag[27];
      selCca:      bit27 = cca[27];
      selEra:      bit27 = era[27];
      default:     bit27 = 1'b0;
    endcase
  end

  // Page table index uses VMA bits 18 to 23.
  always_comb begin
    case (selMid)
      selVma:       midField = vma.flat[28:31];
      selChanWord:  midField = chanWord[28:31];
      selCacheTag:  midField = cacheTag[28:31];
      selCca:       midField = cca[28:31];
      selEra:       midField = era[28:31];
      selPageTable: midField = vma.flat[18:21];
      default:      midField = '0;
    endcase
  end

  always_comb begin
    case (selLow)
      selVma:       lowField = vma.flat[32:35];
      selChanWord:  lowField = chanWord[32:35];
      // Tag holds the line address; word within line stays from the VMA.
      selCacheTag:  lowField = {cacheTag[32:33], vma.flat[34:35]};
      selCca:       lowField = cca[32:35];
      selEra:       lowField = era[32:35];
      selPageTable: lowField = {vma.flat[22:23], 2'b00};
      default:      lowField = '0;
    endcase
  end

  assign pa = {highField, bit27, midField, lowField};

  // ERA follows the address until an ERA grant freezes it.
  always_ff @(posedge clock) begin
    if (!rstN) begin
      era <= '0;
    end else if (!eboxEraGrant) begin
      era <= pa;
    end
  end

  assign adrPar  = ~^pa[14:33];
  assign highPar = ^pa[14:26];

  // Codes the cycle select never produces for these fields.
  selectsValid: assert property (
    @(posedge clock) disable iff (!rstN)
    (selHigh != selZero) && (sel27 != selPageTable) &&
    (selMid != selZero) && (selLow != selZero)
  );

endmodule

// ==== pmaBaseRegs.sv ====
`timescale 1ns/1ps

module pmaBaseRegs #(
  parameter int PageWidth = pmaPkg::PageWidthDefault
) (
  input  logic            clock,
  input  logic            rstN,
  input  pmaPkg::vmaWordT vma,
  input  logic            loadReg,
  input  logic            selUbr,
  input  logic            selEbr,
  input  logic            ubrSel,
  output pmaPkg::baseT    uebr
);

  localparam int BaseLast = 13 + PageWidth;

  logic [14:BaseLast] ubr;
  logic [14:BaseLast] ebr;

  // Base loads come from the page number part of the VMA.
  always_ff @(posedge clock) begin
    if (!rstN) begin
      ubr <= '0;
      ebr <= '0;
    end else if (loadReg) begin
      if (selUbr) begin
        ubr <= vma.flat[14:BaseLast];
      end
      if (selEbr) begin
        ebr <= vma.flat[14:BaseLast];
      end
    end
  end

  assign uebr = ubrSel ? ubr : ebr;

  // Microcode loads one base register at a time.
  loadOneBase: assert property (
    @(posedge clock) disable iff (!rstN)
    loadReg |-> !(selUbr && selEbr)
  );

endmodule

// ==== pmaCcaCounter.sv ====
`timescale 1ns/1ps

module pmaCcaCounter #(
  parameter int CcaWidth = pmaPkg::CcaWidthDefault
) (
  input  logic            clock,
  input  logic            rstN,
  input  pmaPkg::vmaWordT vma,
  input  logic            ccaLoad,
  input  logic            ccaAllPages,
  input  logic            ccaReqGrant,
  output pmaPkg::paddrT   cca,
  output logic            ccaCarryOut
);

  localparam int CountFirst = 36 - CcaWidth;

  logic [14:CountFirst-1] ccaUpper;
  logic [CountFirst:35]   ccaCount;
  logic                   stepPending;

  // The count steps at the end of a granted sweep cycle, so the
  // cycle itself still sees the address it was granted for.
  always_ff @(posedge clock) begin
    if (!rstN) begin
      stepPending <= 1'b0;
    end else begin
      stepPending <= ccaReqGrant && !ccaLoad;
    end
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      ccaUpper <= '0;
      ccaCount <= '0;
    end else if (ccaLoad) begin
      ccaUpper <= vma.flat[14:CountFirst-1];
      ccaCount <= '1;
    end else if (stepPending) begin
      ccaCount <= ccaCount - 1'b1;
    end
  end

  assign cca = {ccaUpper, ccaCount};

  // End of one page, or of the whole sweep in all-pages mode.
  assign ccaCarryOut = (ccaCount[CountFirst:33] == '0) &&
                       (!ccaAllPages || (ccaCount[34:35] == 2'b00));

endmodule

// ==== pmaCycleSelect.sv ====
`timescale 1ns/1ps

module pmaCycleSelect (
  input  logic            clock,
  input  logic            rstN,
  input  pmaPkg::vmaWordT vma,
  input  logic            readyToGo,
  input  logic            eboxReqGrant,
  input  logic            chanReqGrant,
  input  logic            ccaReqGrant,
  input  logic            eboxEraGrant,
  input  logic            eboxCcaGrant,
  input  logic            pageRefillT4,
  input  logic            writebackT2,
  input  logic            vmaUser,
  input  logic            vmaUpt,
  input  logic            vmaEpt,
  input  logic            eboxMayBePaged,
  output pmaPkg::srcSelT  selHigh,
  output pmaPkg::srcSelT  sel27,
  output pmaPkg::srcSelT  selMid,
  output pmaPkg::srcSelT  selLow,
  output logic            ubrSel,
  output logic            pageRefillCyc,
  output logic            eboxCyc,
  output logic            writebackCyc,
  output logic            cycTypeHold
);

  import pmaPkg::*;

  logic   execPerProc;
  logic   refillUsesUbr;
  srcSelT highNext;
  srcSelT bit27Next;
  srcSelT midNext;
  srcSelT lowNext;
  logic   ubrSelNext;

  assign execPerProc = !vma.fields.userPage && (vma.fields.procField == ExecPerProcess);

  // User and per-process refills walk the user page table.
  assign refillUsesUbr = vmaUser || execPerProc;

  // Priority: ERA, refill, channel, writeback, CCA, EBOX, then VMA.
  always_comb begin
    highNext   = selVma;
    bit27Next  = selVma;
    midNext    = selVma;
    lowNext    = selVma;
    ubrSelNext = 1'b0;
    if (eboxEraGrant) begin
      highNext  = selEra;
      bit27Next = selEra;
      midNext   = selEra;
      lowNext   = selEra;
    end else if (pageRefillT4) begin
      // Base plus the VMA page index.
      highNext   = selBase;
      bit27Next  = selZero;
      midNext    = selPageTable;
      lowNext    = selPageTable;
      ubrSelNext = refillUsesUbr;
    end else if (chanReqGrant) begin
      highNext  = selChanWord;
      bit27Next = selChanWord;
      midNext   = selChanWord;
      lowNext   = selChanWord;
    end else if (writebackT2) begin
      highNext  = selCacheTag;
      bit27Next = selCacheTag;
      midNext   = selCacheTag;
      lowNext   = selCacheTag;
    end else if (ccaReqGrant || eboxCcaGrant) begin
      highNext  = selCca;
      bit27Next = selCca;
      midNext   = selCca;
      lowNext   = selCca;
    end else if (eboxReqGrant) begin
      if (vmaUpt || vmaEpt) begin
        highNext   = selBase;
        bit27Next  = selBase;
        midNext    = selBase;
        lowNext    = selBase;
        ubrSelNext = vmaUpt;
      end else if (eboxMayBePaged) begin
        // Page number from the pager, word offset from the VMA.
        highNext = selPageTable;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rstN) begin
      selHigh <= selVma;
      sel27   <= selVma;
      selMid  <= selVma;
      selLow  <= selVma;
      ubrSel  <= 1'b0;
    end else if (readyToGo) begin
      selHigh <= highNext;
      sel27   <= bit27Next;
      selMid  <= midNext;
      selLow  <= lowNext;
      ubrSel  <= ubrSelNext;
    end
  end

  assign cycTypeHold = !readyToGo && !writebackT2;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      pageRefillCyc <= 1'b0;
      eboxCyc       <= 1'b0;
      writebackCyc  <= 1'b0;
    end else if (!cycTypeHold) begin
      pageRefillCyc <= pageRefillT4;
      eboxCyc       <= eboxReqGrant;
      writebackCyc  <= writebackT2;
    end
  end

  // The cache controller never overlaps a refill with a writeback.
  refillNotWriteback: assert property (
    @(posedge clock) disable iff (!rstN)
    !(pageRefillCyc && writebackCyc)
  );

endmodule

// ==== pmaPkg.sv ====
package pmaPkg;

  // Physical address bit range, big-endian numbering.
  localparam int PaFirst = 14;
  localparam int PaLast = 35;

  // Defaults for the top level parameters.
  localparam int PageWidthDefault = 13;
  localparam int CcaWidthDefault = 9;

  // Process field value of an executive per-process page.
  localparam logic [2:0] ExecPerProcess = 3'b111;

  // Physical address, bits 14 to 35.
  typedef logic [PaFirst:PaLast] paddrT;

  // Base register value, bits 14 to 26.
  typedef logic [14:26] baseT;

  // Field view of the VMA.
  typedef struct packed {
    logic [14:17] section;
    logic         userPage;
    logic [19:21] procField;
    logic [22:35] pageWord;
  } vmaFieldsT;

  // VMA word, flat address or fields.
  typedef union packed {
    paddrT     flat;
    vmaFieldsT fields;
  } vmaWordT;

  // Source of one physical address field.
  typedef enum logic [2:0] {
    selVma       = 3'd0,
    selBase      = 3'd1,
    selZero      = 3'd2,
    selChanWord  = 3'd3,
    selCacheTag  = 3'd4,
    selCca       = 3'd5,
    selEra       = 3'd6,
    selPageTable = 3'd7
  } srcSelT;

endpackage

// ==== pmaTbTasks.svh ====
// Drive point, just after the next rising edge.
task automatic driveEdge();
  @(posedge clock);
  #2;
endtask

task automatic clearCycleInputs();
  readyToGo      = 1'b0;
  eboxReqGrant   = 1'b0;
  chanReqGrant   = 1'b0;
  ccaReqGrant    = 1'b0;
  eboxEraGrant   = 1'b0;
  eboxCcaGrant   = 1'b0;
  pageRefillT4   = 1'b0;
  writebackT2    = 1'b0;
  vmaUser        = 1'b0;
  vmaUpt         = 1'b0;
  vmaEpt         = 1'b0;
  eboxMayBePaged = 1'b0;
  loadReg        = 1'b0;
  selUbr         = 1'b0;
  selEbr         = 1'b0;
  ccaLoad        = 1'b0;
endtask

// Start edge comes next; returns in the middle of the cycle after it.
task automatic beginCycle();
  readyToGo = 1'b1;
  driveEdge();
  clearCycleInputs();
  #8;
endtask

function automatic int onesIn(input paddrT w, input int first, input int last);
  int n;
  n = 0;
  for (int i = first; i <= last; i++) begin
    n += w[i];
  end
  return n;
endfunction

task automatic unpagedEbox();
  paddrT expected;
  repeat (8) begin
    driveEdge();
    vma.flat     = randomAddr();
    eboxReqGrant = 1'b1;
    beginCycle();
    expected = vma.flat;
    checkValue("unpaged pa", pa, expected);
    // Odd parity over 14 to 33, even over 14 to 26.
    checkValue("adrPar", adrPar, onesIn(expected, 14, 33) % 2 == 0);
    checkValue("highPar", highPar, onesIn(expected, 14, 26) % 2 == 1);
    checkValue("eboxCyc", eboxCyc, 1'b1);
  end
endtask

task automatic baseRegisters();
  driveEdge();
  vma.flat = randomAddr();
  ubrVal   = vma.flat[14:26];
  loadReg  = 1'b1;
  selUbr   = 1'b1;
  driveEdge();
  clearCycleInputs();
  vma.flat = randomAddr();
  ebrVal   = vma.flat[14:26];
  if (ebrVal == ubrVal) begin
    ebrVal = ~ubrVal;
  end
  vma.flat[14:26] = ebrVal;
  loadReg         = 1'b1;
  selEbr          = 1'b1;
  driveEdge();
  clearCycleInputs();
  vma.flat     = randomAddr();
  eboxReqGrant = 1'b1;
  vmaUpt       = 1'b1;
  beginCycle();
  checkValue("UPT base pa", pa, {ubrVal, 9'b0});
  driveEdge();
  eboxReqGrant = 1'b1;
  vmaEpt       = 1'b1;
  beginCycle();
  checkValue("EPT base pa", pa, {ebrVal, 9'b0});
endtask

// Base, a zero bit, VMA bits 18 to 23, then two zero bits.
task automatic refillCase(input string what, input logic userRef,
                          input logic [2:0] proc, input baseT base);
  paddrT expected;
  driveEdge();
  vma.flat            = randomAddr();
  vma.fields.userPage = userRef;
  vma.fields.procField = proc;
  vmaUser             = userRef;
  pageRefillT4        = 1'b1;
  beginCycle();
  expected = {base, 1'b0, vma.flat[18:23], 2'b00};
  checkValue(what, pa, expected);
  checkValue("pageRefillCyc", pageRefillCyc, 1'b1);
endtask

task automatic pageRefill();
  refillCase("user refill pa", 1'b1, 3'b011, ubrVal);
  refillCase("exec per-process refill pa", 1'b0, 3'b111, ubrVal);
  refillCase("exec refill pa", 1'b0, 3'b101, ebrVal);
endtask

task automatic cacheSweep();
  baseT       upper;
  logic [8:0] count;
  logic       allPages;
  logic       done;
  int         steps;
  driveEdge();
  vma.flat    = randomAddr();
  upper       = vma.flat[14:26];
  ccaLoad     = 1'b1;
  ccaAllPages = 1'b0;
  driveEdge();
  clearCycleInputs();
  count    = '1;
  allPages = 1'b0;
  done     = 1'b0;
  steps    = 0;
  // One page first, then on to the end in all-pages mode.
  while (!done && steps < 600) begin
    ccaAllPages = allPages;
    ccaReqGrant = 1'b1;
    beginCycle();
    checkValue("sweep pa", pa, {upper, count});
    checkValue("ccaCarryOut", ccaCarryOut,
               allPages ? (count == 9'd0) : (count[8:2] == 7'd0));
    done = allPages && ccaCarryOut;
    if (!allPages && count[8:2] == 7'd0) begin
      allPages = 1'b1;
    end
    count = count - 1'b1;
    steps++;
    driveEdge();
  end
  if (!done) begin
    timeoutCount++;
    $display("Timeout: ccaCarryOut did not rise at the end of the sweep");
  end
  ccaAllPages = 1'b0;
endtask

task automatic writebackEra();
  paddrT wbAddr;
  driveEdge();
  vma.flat    = randomAddr();
  cacheTag    = randomAddr();
  writebackT2 = 1'b1;
  beginCycle();
  wbAddr = {cacheTag[14:33], vma.flat[34:35]};
  checkValue("writeback pa", pa, wbAddr);
  checkValue("writebackCyc", writebackCyc, 1'b1);
  // Other sources move away; the ERA keeps the old address.
  driveEdge();
  vma.flat     = randomAddr();
  cacheTag     = randomAddr();
  eboxEraGrant = 1'b1;
  beginCycle();
  checkValue("ERA readback pa", pa, wbAddr);
  checkValue("writebackCyc after ERA", writebackCyc, 1'b0);
endtask

task automatic holdCycle();
  paddrT held;
  driveEdge();
  vma.flat     = randomAddr();
  eboxReqGrant = 1'b1;
  beginCycle();
  held = vma.flat;
  checkValue("hold start pa", pa, held);
  repeat (4) begin
    driveEdge();
    chanWord     = randomAddr();
    chanReqGrant = 1'b1;
    pageRefillT4 = 1'b1;
    #8;
    checkValue("held pa", pa, held);
    checkValue("held eboxCyc", eboxCyc, 1'b1);
    checkValue("held pageRefillCyc", pageRefillCyc, 1'b0);
  end
  driveEdge();
  clearCycleInputs();
endtask

// ==== pmaTb.sv ====
`timescale 1ns/1ps

module pmaTb;

  import pmaPkg::*;

  logic        clock;
  logic        rstN;
  vmaWordT     vma;
  logic        loadReg;
  logic        selUbr;
  logic        selEbr;
  logic        ccaLoad;
  logic        ccaAllPages;
  logic        readyToGo;
  logic        eboxReqGrant;
  logic        chanReqGrant;
  logic        ccaReqGrant;
  logic        eboxEraGrant;
  logic        eboxCcaGrant;
  logic        pageRefillT4;
  logic        writebackT2;
  logic        vmaUser;
  logic        vmaUpt;
  logic        vmaEpt;
  logic        eboxMayBePaged;
  paddrT       pageTable;
  paddrT       chanWord;
  paddrT       cacheTag;
  paddrT       pa;
  logic        adrPar;
  logic        highPar;
  logic        ccaCarryOut;
  logic        pageRefillCyc;
  logic        eboxCyc;
  logic        writebackCyc;

  logic [15:0] lfsr;
  int          checkCount;
  int          mismatchCount;
  int          timeoutCount;
  baseT        ubrVal;
  baseT        ebrVal;

  pmaTop #(
    .PageWidth(PageWidthDefault),
    .CcaWidth (CcaWidthDefault)
  ) dut_i (
    .clock         (clock),
    .rstN          (rstN),
    .vma           (vma),
    .loadReg       (loadReg),
    .selUbr        (selUbr),
    .selEbr        (selEbr),
    .ccaLoad       (ccaLoad),
    .ccaAllPages   (ccaAllPages),
    .readyToGo     (readyToGo),
    .eboxReqGrant  (eboxReqGrant),
    .chanReqGrant  (chanReqGrant),
    .ccaReqGrant   (ccaReqGrant),
    .eboxEraGrant  (eboxEraGrant),
    .eboxCcaGrant  (eboxCcaGrant),
    .pageRefillT4  (pageRefillT4),
    .writebackT2   (writebackT2),
    .vmaUser       (vmaUser),
    .vmaUpt        (vmaUpt),
    .vmaEpt        (vmaEpt),
    .eboxMayBePaged(eboxMayBePaged),
    .pageTable     (pageTable),
    .chanWord      (chanWord),
    .cacheTag      (cacheTag),
    .pa            (pa),
    .adrPar        (adrPar),
    .highPar       (highPar),
    .ccaCarryOut   (ccaCarryOut),
    .pageRefillCyc (pageRefillCyc),
    .eboxCyc       (eboxCyc),
    .writebackCyc  (writebackCyc)
  );

  always #10 clock = ~clock;

  // Galois form of x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic paddrT randomAddr();
    paddrT w;
    w = '0;
    for (int i = PaFirst; i <= PaLast; i++) begin
      lfsr = lfsrNext(lfsr);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  task automatic checkValue(input string what, input logic [31:0] got,
                            input logic [31:0] expected);
    checkCount++;
    assert (got === expected) else begin
      mismatchCount++;
      $display("Mismatch at %0t: %s got %h, expected %h", $time, what, got, expected);
    end
  endtask

  `include "pmaTbTasks.svh"

  initial begin
    clock         = 1'b0;
    rstN          = 1'b0;
    lfsr          = 16'd26;
    checkCount    = 0;
    mismatchCount = 0;
    timeoutCount  = 0;
    vma           = '0;
    ccaAllPages   = 1'b0;
    pageTable     = '0;
    chanWord      = '0;
    cacheTag      = '0;
    clearCycleInputs();
    repeat (2) @(posedge clock);
    #2;
    rstN = 1'b1;
    unpagedEbox();
    baseRegisters();
    pageRefill();
    cacheSweep();
    writebackEra();
    holdCycle();
    $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
             checkCount, mismatchCount, timeoutCount);
    if (mismatchCount == 0 && timeoutCount == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== pmaTop.sv ====
`timescale 1ns/1ps

module pmaTop #(
  parameter int PageWidth = pmaPkg::PageWidthDefault,
  parameter int CcaWidth  = pmaPkg::CcaWidthDefault
) (
  input  logic            clock,
  input  logic            rstN,
  input  pmaPkg::vmaWordT vma,
  input  logic            loadReg,
  input  logic            selUbr,
  input  logic            selEbr,
  input  logic            ccaLoad,
  input  logic            ccaAllPages,
  input  logic            readyToGo,
  input  logic            eboxReqGrant,
  input  logic            chanReqGrant,
  input  logic            ccaReqGrant,
  input  logic            eboxEraGrant,
  input  logic            eboxCcaGrant,
  input  logic            pageRefillT4,
  input  logic            writebackT2,
  input  logic            vmaUser,
  input  logic            vmaUpt,
  input  logic            vmaEpt,
  input  logic            eboxMayBePaged,
  input  pmaPkg::paddrT   pageTable,
  input  pmaPkg::paddrT   chanWord,
  input  pmaPkg::paddrT   cacheTag,
  output pmaPkg::paddrT   pa,
  output logic            adrPar,
  output logic            highPar,
  output logic            ccaCarryOut,
  output logic            pageRefillCyc,
  output logic            eboxCyc,
  output logic            writebackCyc
);

  import pmaPkg::*;

  baseT   uebr;
  logic   ubrSel;
  paddrT  cca;
  srcSelT selHigh;
  srcSelT sel27;
  srcSelT selMid;
  srcSelT selLow;

  pmaBaseRegs #(
    .PageWidth(PageWidth)
  ) baseRegs (
    .clock  (clock),
    .rstN   (rstN),
    .vma    (vma),
    .loadReg(loadReg),
    .selUbr (selUbr),
    .selEbr (selEbr),
    .ubrSel (ubrSel),
    .uebr   (uebr)
  );

  pmaCcaCounter #(
    .CcaWidth(CcaWidth)
  ) ccaCounter (
    .clock      (clock),
    .rstN       (rstN),
    .vma        (vma),
    .ccaLoad    (ccaLoad),
    .ccaAllPages(ccaAllPages),
    .ccaReqGrant(ccaReqGrant),
    .cca        (cca),
    .ccaCarryOut(ccaCarryOut)
  );

  pmaCycleSelect cycleSelect (
    .clock         (clock),
    .rstN          (rstN),
    .vma           (vma),
    .readyToGo     (readyToGo),
    .eboxReqGrant  (eboxReqGrant),
    .chanReqGrant  (chanReqGrant),
    .ccaReqGrant   (ccaReqGrant),
    .eboxEraGrant  (eboxEraGrant),
    .eboxCcaGrant  (eboxCcaGrant),
    .pageRefillT4  (pageRefillT4),
    .writebackT2   (writebackT2),
    .vmaUser       (vmaUser),
    .vmaUpt        (vmaUpt),
    .vmaEpt        (vmaEpt),
    .eboxMayBePaged(eboxMayBePaged),
    .selHigh       (selHigh),
    .sel27         (sel27),
    .selMid        (selMid),
    .selLow        (selLow),
    .ubrSel        (ubrSel),
    .pageRefillCyc (pageRefillCyc),
    .eboxCyc       (eboxCyc),
    .writebackCyc  (writebackCyc),
    .cycTypeHold   ()
  );

  pmaAddressMux #(
    .PageWidth(PageWidth)
  ) addressMux (
    .clock       (clock),
    .rstN        (rstN),
    .selHigh     (selHigh),
    .sel27       (sel27),
    .selMid      (selMid),
    .selLow      (selLow),
    .vma         (vma),
    .uebr        (uebr),
    .cca         (cca),
    .pageTable   (pageTable),
    .chanWord    (chanWord),
    .cacheTag    (cacheTag),
    .eboxEraGrant(eboxEraGrant),
    .pa          (pa),
    .adrPar      (adrPar),
    .highPar     (highPar)
  );

endmodule
